/* dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Address and data width of both AXI-lite ports and of the sample stream
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 32

// Number of samples the input FIFO can hold before it back-pressures
`define DMA_FIFO_DEPTH 8

// Byte offsets of the host registers
`define DMA_REG_BASE    8'h00
`define DMA_REG_LENGTH  8'h04
`define DMA_REG_CONTROL 8'h08
`define DMA_REG_STATUS  8'h0C

`endif

/* dma_pkg.sv */
`include "dma_cfg.svh"

package dma_pkg;

    // Only OKAY is ever produced as an AXI-lite response here
    typedef enum logic [1:0] {
        AXI_RESP_OKAY = 2'b00
    } axi_resp_t;

    // Buffer setup handed from the register block to the write master
    // Length counts words, so the buffer spans base to base plus four times length
    typedef struct packed {
        logic [`DMA_ADDR_WIDTH-1:0] base;
        logic [`DMA_DATA_WIDTH-1:0] length;
        logic                       enable;
    } dma_config_t;

endpackage

/* axi_lite_if.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

interface axi_lite_if;

    // Write address channel
    logic [`DMA_ADDR_WIDTH-1:0]   awaddr;
    logic                         awvalid;
    logic                         awready;

    // Write data channel with one strobe bit per byte
    logic [`DMA_DATA_WIDTH-1:0]   wdata;
    logic [`DMA_DATA_WIDTH/8-1:0] wstrb;
    logic                         wvalid;
    logic                         wready;

    // Write response channel
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;

    // Read address and read data channels
    logic [`DMA_ADDR_WIDTH-1:0]   araddr;
    logic                         arvalid;
    logic                         arready;
    logic [`DMA_DATA_WIDTH-1:0]   rdata;
    logic [1:0]                   rresp;
    logic                         rvalid;
    logic                         rready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

/* axil_dma_regs.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module axil_dma_regs import dma_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    axi_lite_if.slave   host,
    output dma_config_t dma_config,
    input  logic        sample_written
);

    localparam int DATA_WIDTH = `DMA_DATA_WIDTH;

    logic [DATA_WIDTH-1:0] base_reg;
    logic [DATA_WIDTH-1:0] length_reg;
    logic [DATA_WIDTH-1:0] sample_count;
    logic                  enable_reg;
    logic                  restart;
    logic                  write_fire;
    logic                  read_fire;

    // Merge the bytes selected by the strobe into the old register value
    function automatic logic [DATA_WIDTH-1:0] apply_strobe(
        input logic [DATA_WIDTH-1:0]   old_value,
        input logic [DATA_WIDTH-1:0]   new_value,
        input logic [DATA_WIDTH/8-1:0] strobe
    );
        logic [DATA_WIDTH-1:0] result;
        result = old_value;
        for (int i = 0; i < DATA_WIDTH / 8; i++) begin
            if (strobe[i]) result[8*i +: 8] = new_value[8*i +: 8];
        end
        return result;
    endfunction

    // awready and wready pulse together, so one edge completes both channels
    assign write_fire = host.awvalid && host.awready && host.wvalid && host.wready;
    assign read_fire  = host.arvalid && host.arready;
    assign host.bresp = AXI_RESP_OKAY;
    assign host.rresp = AXI_RESP_OKAY;

    // Enable is held low for one cycle after an enable write so the master restarts at zero
    assign dma_config.base   = base_reg;
    assign dma_config.length = length_reg;
    assign dma_config.enable = enable_reg && !restart;

    always_ff @(posedge clock) begin
        if (reset) begin
            host.awready <= 1'b0;
            host.wready  <= 1'b0;
            host.bvalid  <= 1'b0;
        end else begin
            // Accept only when both channels are present and no response is pending
            host.awready <= host.awvalid && host.wvalid && !host.awready && !host.bvalid;
            host.wready  <= host.awvalid && host.wvalid && !host.awready && !host.bvalid;
            if (write_fire) begin
                host.bvalid <= 1'b1;
            end else if (host.bready) begin
                host.bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            base_reg     <= '0;
            length_reg   <= '0;
            enable_reg   <= 1'b0;
            restart      <= 1'b0;
            sample_count <= '0;
        end else begin
            restart <= 1'b0;
            if (sample_written) sample_count <= sample_count + 1'b1;
            if (write_fire) begin
                case (host.awaddr[7:0])
                    `DMA_REG_BASE:   base_reg   <= apply_strobe(base_reg, host.wdata, host.wstrb);
                    `DMA_REG_LENGTH: length_reg <= apply_strobe(length_reg, host.wdata, host.wstrb);
                    `DMA_REG_CONTROL: begin
                        if (host.wstrb[0]) begin
                            enable_reg <= host.wdata[0];
                            // A fresh enable starts a new run, so the count starts over
                            if (host.wdata[0]) begin
                                restart      <= 1'b1;
                                sample_count <= '0;
                            end
                        end
                    end
                    // STATUS is read only and other offsets are not mapped
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            host.arready <= 1'b0;
            host.rvalid  <= 1'b0;
            host.rdata   <= '0;
        end else begin
            host.arready <= host.arvalid && !host.arready && !host.rvalid;
            if (read_fire) begin
                host.rvalid <= 1'b1;
                case (host.araddr[7:0])
                    `DMA_REG_BASE:    host.rdata <= base_reg;
                    `DMA_REG_LENGTH:  host.rdata <= length_reg;
                    `DMA_REG_CONTROL: host.rdata <= {{(DATA_WIDTH-1){1'b0}}, enable_reg};
                    `DMA_REG_STATUS:  host.rdata <= sample_count;
                    default:          host.rdata <= '0;
                endcase
            end else if (host.rready) begin
                host.rvalid <= 1'b0;
            end
        end
    end

endmodule

/* stream_fifo.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module stream_fifo #(
    parameter int WIDTH = `DMA_DATA_WIDTH,
    parameter int DEPTH = `DMA_FIFO_DEPTH
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int PTR_WIDTH = $clog2(DEPTH);
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     storage [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 push;
    logic                 pop;

    // Ready only drops when every slot is taken
    assign in_ready  = count != CNT_WIDTH'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = storage[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) storage[wr_ptr] <= in_data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap explicitly, so the depth need not be a power of two
            if (push) wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // A push and a pop on the same edge leave the count unchanged
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* axil_write_master.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module axil_write_master import dma_pkg::*; (
    input  logic                       clock,
    input  logic                       reset,
    input  dma_config_t                dma_config,
    input  logic [`DMA_DATA_WIDTH-1:0] in_data,
    input  logic                       in_valid,
    output logic                       in_ready,
    axi_lite_if.master                 mem,
    output logic                       sample_written
);

    localparam int ADDR_WIDTH = `DMA_ADDR_WIDTH;
    localparam int DATA_WIDTH = `DMA_DATA_WIDTH;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_RESP
    } state_t;

    state_t                state;
    logic [DATA_WIDTH-1:0] index;
    logic [DATA_WIDTH-1:0] next_index;
    logic [ADDR_WIDTH-1:0] write_addr;
    logic                  active;
    logic                  aw_done;
    logic                  w_done;
    logic                  b_fire;

    // A zero length buffer behaves as if the engine were disabled
    assign active     = dma_config.enable && (dma_config.length != '0);
    assign write_addr = dma_config.base + (ADDR_WIDTH'(index) << 2);
    assign next_index = (index + 1'b1 >= dma_config.length) ? '0 : index + 1'b1;

    // A channel counts as done once its valid is low or is being accepted now
    assign aw_done = !mem.awvalid || mem.awready;
    assign w_done  = !mem.wvalid || mem.wready;
    assign b_fire  = (state == WAIT_RESP) && mem.bvalid;

    // The FIFO head is popped only once memory has confirmed the write
    assign mem.bready = (state == WAIT_RESP);
    assign in_ready   = b_fire;

    // Full word writes only, and the read channel is never used
    assign mem.wstrb   = '1;
    assign mem.araddr  = '0;
    assign mem.arvalid = 1'b0;
    assign mem.rready  = 1'b0;

    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= IDLE;
            mem.awvalid    <= 1'b0;
            mem.awaddr     <= '0;
            mem.wvalid     <= 1'b0;
            mem.wdata      <= '0;
            index          <= '0;
            sample_written <= 1'b0;
        end else begin
            sample_written <= 1'b0;
            case (state)
                IDLE: begin
                    if (active && in_valid) begin
                        mem.awvalid <= 1'b1;
                        mem.awaddr  <= write_addr;
                        mem.wvalid  <= 1'b1;
                        mem.wdata   <= in_data;
                        state       <= REQUEST;
                    end
                end
                REQUEST: begin
                    // Address and data may be accepted on different edges
                    if (mem.awready) mem.awvalid <= 1'b0;
                    if (mem.wready) mem.wvalid <= 1'b0;
                    if (aw_done && w_done) state <= WAIT_RESP;
                end
                WAIT_RESP: begin
                    if (mem.bvalid) begin
                        sample_written <= (mem.bresp == AXI_RESP_OKAY);
                        index          <= next_index;
                        state          <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            // Disabling rewinds the buffer, which also wins over an advance above
            if (!active) index <= '0;
        end
    end

endmodule

/* axil_dma.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module axil_dma import dma_pkg::*; (
    input  logic                         clock,
    input  logic                         reset,
    // Host register port
    input  logic [`DMA_ADDR_WIDTH-1:0]   axi_in_awaddr,
    input  logic                         axi_in_awvalid,
    output logic                         axi_in_awready,
    input  logic [`DMA_DATA_WIDTH-1:0]   axi_in_wdata,
    input  logic [`DMA_DATA_WIDTH/8-1:0] axi_in_wstrb,
    input  logic                         axi_in_wvalid,
    output logic                         axi_in_wready,
    output logic [1:0]                   axi_in_bresp,
    output logic                         axi_in_bvalid,
    input  logic                         axi_in_bready,
    input  logic [`DMA_ADDR_WIDTH-1:0]   axi_in_araddr,
    input  logic                         axi_in_arvalid,
    output logic                         axi_in_arready,
    output logic [`DMA_DATA_WIDTH-1:0]   axi_in_rdata,
    output logic [1:0]                   axi_in_rresp,
    output logic                         axi_in_rvalid,
    input  logic                         axi_in_rready,
    // Memory write port
    output logic [`DMA_ADDR_WIDTH-1:0]   axi_out_awaddr,
    output logic                         axi_out_awvalid,
    input  logic                         axi_out_awready,
    output logic [`DMA_DATA_WIDTH-1:0]   axi_out_wdata,
    output logic [`DMA_DATA_WIDTH/8-1:0] axi_out_wstrb,
    output logic                         axi_out_wvalid,
    input  logic                         axi_out_wready,
    input  logic [1:0]                   axi_out_bresp,
    input  logic                         axi_out_bvalid,
    output logic                         axi_out_bready,
    // Sample stream
    input  logic [`DMA_DATA_WIDTH-1:0]   data_in_data,
    input  logic                         data_in_valid,
    output logic                         data_in_ready
);

    axi_lite_if host_bus ();
    axi_lite_if mem_bus ();

    dma_config_t                dma_config;
    logic                       sample_written;
    logic [`DMA_DATA_WIDTH-1:0] fifo_data;
    logic                       fifo_valid;
    logic                       fifo_ready;

    // Host port onto its bus
    assign host_bus.awaddr  = axi_in_awaddr;
    assign host_bus.awvalid = axi_in_awvalid;
    assign host_bus.wdata   = axi_in_wdata;
    assign host_bus.wstrb   = axi_in_wstrb;
    assign host_bus.wvalid  = axi_in_wvalid;
    assign host_bus.bready  = axi_in_bready;
    assign host_bus.araddr  = axi_in_araddr;
    assign host_bus.arvalid = axi_in_arvalid;
    assign host_bus.rready  = axi_in_rready;
    assign axi_in_awready   = host_bus.awready;
    assign axi_in_wready    = host_bus.wready;
    assign axi_in_bresp     = host_bus.bresp;
    assign axi_in_bvalid    = host_bus.bvalid;
    assign axi_in_arready   = host_bus.arready;
    assign axi_in_rdata     = host_bus.rdata;
    assign axi_in_rresp     = host_bus.rresp;
    assign axi_in_rvalid    = host_bus.rvalid;

    // The memory port carries the write channels only
    assign axi_out_awaddr   = mem_bus.awaddr;
    assign axi_out_awvalid  = mem_bus.awvalid;
    assign axi_out_wdata    = mem_bus.wdata;
    assign axi_out_wstrb    = mem_bus.wstrb;
    assign axi_out_wvalid   = mem_bus.wvalid;
    assign axi_out_bready   = mem_bus.bready;
    assign mem_bus.awready  = axi_out_awready;
    assign mem_bus.wready   = axi_out_wready;
    assign mem_bus.bresp    = axi_out_bresp;
    assign mem_bus.bvalid   = axi_out_bvalid;

    // The master never reads, so the read side of its bus stays idle
    assign mem_bus.arready  = 1'b0;
    assign mem_bus.rdata    = '0;
    assign mem_bus.rresp    = AXI_RESP_OKAY;
    assign mem_bus.rvalid   = 1'b0;

    axil_dma_regs regs_i (
        .clock          (clock),
        .reset          (reset),
        .host           (host_bus.slave),
        .dma_config     (dma_config),
        .sample_written (sample_written)
    );

    stream_fifo fifo_i (
        .clock     (clock),
        .reset     (reset),
        .in_data   (data_in_data),
        .in_valid  (data_in_valid),
        .in_ready  (data_in_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    axil_write_master master_i (
        .clock          (clock),
        .reset          (reset),
        .dma_config     (dma_config),
        .in_data        (fifo_data),
        .in_valid       (fifo_valid),
        .in_ready       (fifo_ready),
        .mem            (mem_bus.master),
        .sample_written (sample_written)
    );

endmodule

/* axil_dma_tb.sv */
`timescale 1ns/1ps
`include "dma_cfg.svh"

module axil_dma_tb;

    localparam int AW = `DMA_ADDR_WIDTH;
    localparam int DW = `DMA_DATA_WIDTH;
    localparam int DEPTH = `DMA_FIFO_DEPTH;
    localparam int WAIT_LIMIT = 2000;

    logic            clock = 1'b0;
    logic            reset;
    logic [AW-1:0]   axi_in_awaddr;
    logic            axi_in_awvalid;
    logic            axi_in_awready;
    logic [DW-1:0]   axi_in_wdata;
    logic [DW/8-1:0] axi_in_wstrb;
    logic            axi_in_wvalid;
    logic            axi_in_wready;
    logic [1:0]      axi_in_bresp;
    logic            axi_in_bvalid;
    logic            axi_in_bready;
    logic [AW-1:0]   axi_in_araddr;
    logic            axi_in_arvalid;
    logic            axi_in_arready;
    logic [DW-1:0]   axi_in_rdata;
    logic [1:0]      axi_in_rresp;
    logic            axi_in_rvalid;
    logic            axi_in_rready;
    logic [AW-1:0]   axi_out_awaddr;
    logic            axi_out_awvalid;
    logic            axi_out_awready = 1'b0;
    logic [DW-1:0]   axi_out_wdata;
    logic [DW/8-1:0] axi_out_wstrb;
    logic            axi_out_wvalid;
    logic            axi_out_wready = 1'b0;
    logic [1:0]      axi_out_bresp = 2'b00;
    logic            axi_out_bvalid = 1'b0;
    logic            axi_out_bready;
    logic [DW-1:0]   data_in_data;
    logic            data_in_valid;
    logic            data_in_ready;

    // Memory responder state
    logic          stall_memory = 1'b0;
    logic          aw_held = 1'b0;
    logic          w_held = 1'b0;
    logic          b_done = 1'b0;
    int            b_delay = 0;
    logic [AW-1:0] held_addr;
    logic [DW-1:0] held_data;
    logic [DW-1:0] memory [logic [AW-1:0]];
    logic [AW-1:0] log_addr_q [$];
    logic [DW-1:0] log_data_q [$];
    int            write_total = 0;

    // Reference model of the current run
    logic [DW-1:0] sent_q [$];
    logic [AW-1:0] run_base;
    int            run_length;
    int            run_index;
    int            run_start;

    int error_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    axil_dma axil_dma_i (.*);

    always #10 clock = ~clock;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected 0x%0h got 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_error(input string reason);
        $display("Error: %s", reason);
        error_count++;
    endtask

    task automatic abort_run(input string reason);
        $display("Timeout: %s", reason);
        $display("Regression failed");
        $finish;
    endtask

    // Handshakes are decided on the falling edge and complete on the next rising edge
    always @(negedge clock) begin
        if (reset) begin
            axi_out_awready = 1'b0;
            axi_out_wready  = 1'b0;
            axi_out_bvalid  = 1'b0;
            aw_held = 1'b0;
            w_held  = 1'b0;
            b_done  = 1'b0;
        end else begin
            if (b_done) begin
                axi_out_bvalid = 1'b0;
                b_done = 1'b0;
            end else if (aw_held && w_held && !axi_out_bvalid) begin
                // The response comes only after both channels have been taken
                if (b_delay == 0) axi_out_bvalid = 1'b1;
                else b_delay--;
            end
            axi_out_awready = !stall_memory || ($urandom_range(0, 2) == 0);
            axi_out_wready  = !stall_memory || ($urandom_range(0, 2) == 0);
            if (axi_out_awvalid && axi_out_awready) begin
                held_addr = axi_out_awaddr;
                aw_held = 1'b1;
                b_delay = $urandom_range(0, 3);
            end
            if (axi_out_wvalid && axi_out_wready) begin
                held_data = axi_out_wdata;
                w_held = 1'b1;
                compare_value("axi_out_wstrb", 32'hf, 32'(axi_out_wstrb));
            end
            if (axi_out_bvalid && axi_out_bready) begin
                memory[held_addr] = held_data;
                log_addr_q.push_back(held_addr);
                log_data_q.push_back(held_data);
                write_total++;
                aw_held = 1'b0;
                w_held = 1'b0;
                b_done = 1'b1;
            end
        end
    end

    // Host tasks start and end on a falling edge
    task automatic write_reg(input logic [7:0] offset, input logic [31:0] value);
        int waited;
        waited = 0;
        axi_in_awaddr  = {24'h0, offset};
        axi_in_wdata   = value;
        axi_in_wstrb   = '1;
        axi_in_awvalid = 1'b1;
        axi_in_wvalid  = 1'b1;
        axi_in_bready  = 1'b1;
        while (!(axi_in_awready && axi_in_wready)) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("host write was never accepted");
        end
        @(negedge clock);
        axi_in_awvalid = 1'b0;
        axi_in_wvalid  = 1'b0;
        waited = 0;
        while (!axi_in_bvalid) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("host write response never arrived");
        end
        // Every register write completes with an OKAY response
        compare_value("axi_in_bresp", 0, 32'(axi_in_bresp));
        @(negedge clock);
        axi_in_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] offset, output logic [31:0] value);
        int waited;
        waited = 0;
        axi_in_araddr  = {24'h0, offset};
        axi_in_arvalid = 1'b1;
        axi_in_rready  = 1'b1;
        while (!axi_in_arready) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("host read address was never accepted");
        end
        @(negedge clock);
        axi_in_arvalid = 1'b0;
        waited = 0;
        while (!axi_in_rvalid) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("host read data never arrived");
        end
        value = axi_in_rdata;
        // Reads of any offset also answer OKAY
        compare_value("axi_in_rresp", 0, 32'(axi_in_rresp));
        @(negedge clock);
        axi_in_rready = 1'b0;
    endtask

    // Sends one sample after a random idle gap and holds it until the FIFO takes it
    task automatic send_sample(input logic [31:0] value);
        int waited;
        waited = 0;
        repeat ($urandom_range(0, 2)) @(negedge clock);
        data_in_data  = value;
        data_in_valid = 1'b1;
        while (!data_in_ready) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("stream sample was never accepted");
        end
        sent_q.push_back(value);
        @(negedge clock);
        data_in_valid = 1'b0;
    endtask

    // Wait until the target write count is reached and the master is idle again
    task automatic wait_for_writes(input int target);
        int waited;
        waited = 0;
        while (write_total < target || axi_out_bready || axi_out_awvalid) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("memory writes stopped before the last sample");
        end
    endtask

    task automatic start_run(input logic [31:0] base, input int length);
        write_reg(`DMA_REG_BASE, base);
        write_reg(`DMA_REG_LENGTH, 32'(length));
        write_reg(`DMA_REG_CONTROL, 32'h1);
        run_base   = base;
        run_length = length;
        run_index  = 0;
        run_start  = write_total;
    endtask

    // Write n of a run lands at base plus four times n modulo length
    task automatic check_writes();
        logic [31:0] exp_addr;
        while (log_addr_q.size() > 0) begin
            exp_addr = run_base + 32'(4 * (run_index % run_length));
            if (sent_q.size() == 0) begin
                report_error($sformatf("write to 0x%0h has no accepted sample", log_addr_q[0]));
            end else begin
                compare_value("axi_out_awaddr", exp_addr, log_addr_q[0]);
                compare_value("axi_out_wdata", sent_q.pop_front(), log_data_q[0]);
            end
            void'(log_addr_q.pop_front());
            void'(log_data_q.pop_front());
            run_index++;
        end
    endtask

    task automatic check_status();
        logic [31:0] value;
        read_reg(`DMA_REG_STATUS, value);
        compare_value("STATUS", 32'(write_total - run_start), value);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_registers();
        logic [31:0] value;
        int          errors_before;
        errors_before = error_count;
        compare_value("axi_out_awvalid", 0, 32'(axi_out_awvalid));
        compare_value("axi_out_wvalid", 0, 32'(axi_out_wvalid));
        compare_value("axi_out_bready", 0, 32'(axi_out_bready));
        read_reg(`DMA_REG_BASE, value);
        compare_value("BASE", 0, value);
        read_reg(`DMA_REG_LENGTH, value);
        compare_value("LENGTH", 0, value);
        read_reg(`DMA_REG_CONTROL, value);
        compare_value("CONTROL", 0, value);
        read_reg(`DMA_REG_STATUS, value);
        compare_value("STATUS", 0, value);
        start_run(32'h3F00_0000, 120);
        read_reg(`DMA_REG_BASE, value);
        compare_value("BASE", 32'h3F00_0000, value);
        read_reg(`DMA_REG_LENGTH, value);
        compare_value("LENGTH", 120, value);
        read_reg(`DMA_REG_CONTROL, value);
        compare_value("CONTROL", 1, value);
        check_status();
        finish_test("reset and register readback", errors_before);
    endtask

    task automatic test_ordered(input int count);
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < count; i++) send_sample($urandom());
        wait_for_writes(run_start + count);
        compare_value("write count", 32'(count), 32'(write_total - run_start));
        check_writes();
        check_status();
        finish_test("ordered storage", errors_before);
    endtask

    task automatic test_wrap();
        logic [31:0] samples [20];
        logic [31:0] addr;
        int          errors_before;
        int          last;
        errors_before = error_count;
        start_run(32'h2000_0000, 7);
        for (int i = 0; i < 20; i++) begin
            samples[i] = $urandom();
            send_sample(samples[i]);
        end
        wait_for_writes(run_start + 20);
        check_writes();
        for (int j = 0; j < 7; j++) begin
            addr = 32'h2000_0000 + 32'(4 * j);
            last = j + 7 * ((19 - j) / 7);
            if (!memory.exists(addr)) report_error($sformatf("no write reached 0x%0h", addr));
            else compare_value($sformatf("memory[0x%0h]", addr), samples[last], memory[addr]);
        end
        check_status();
        finish_test("circular wrap", errors_before);
    endtask

    task automatic test_stalls();
        int errors_before;
        errors_before = error_count;
        stall_memory = 1'b1;
        start_run(32'h1000_0000, 16);
        for (int i = 0; i < 60; i++) send_sample($urandom());
        wait_for_writes(run_start + 60);
        compare_value("write count", 60, 32'(write_total - run_start));
        check_writes();
        compare_value("unwritten samples", 0, 32'(sent_q.size()));
        stall_memory = 1'b0;
        check_status();
        finish_test("memory back-pressure", errors_before);
    endtask

    task automatic test_disable();
        int   errors_before;
        int   writes_before;
        int   accepted;
        logic took;
        errors_before = error_count;
        accepted = 0;
        write_reg(`DMA_REG_CONTROL, 32'h0);
        writes_before = write_total;
        data_in_data  = $urandom();
        data_in_valid = 1'b1;
        // Keep offering samples well past the FIFO depth
        for (int cycle = 0; cycle < 4 * DEPTH; cycle++) begin
            took = data_in_ready;
            if (took) begin
                sent_q.push_back(data_in_data);
                accepted++;
            end
            @(negedge clock);
            if (took) data_in_data = $urandom();
        end
        data_in_valid = 1'b0;
        compare_value("data_in_ready", 0, 32'(data_in_ready));
        compare_value("writes while disabled", 0, 32'(write_total - writes_before));
        if (accepted > DEPTH) report_error($sformatf("%0d samples taken while disabled", accepted));
        start_run(32'h3F00_0000, 120);
        wait_for_writes(run_start + accepted);
        compare_value("write count", 32'(accepted), 32'(write_total - run_start));
        check_writes();
        check_status();
        finish_test("disable and re-enable", errors_before);
    endtask

    initial begin
        void'($urandom(63577));
        reset          = 1'b1;
        axi_in_awaddr  = '0;
        axi_in_awvalid = 1'b0;
        axi_in_wdata   = '0;
        axi_in_wstrb   = '0;
        axi_in_wvalid  = 1'b0;
        axi_in_bready  = 1'b0;
        axi_in_araddr  = '0;
        axi_in_arvalid = 1'b0;
        axi_in_rready  = 1'b0;
        data_in_data   = '0;
        data_in_valid  = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        test_registers();
        test_ordered(101);
        test_wrap();
        test_stalls();
        test_disable();
        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+.
dma_pkg.sv
axi_lite_if.sv
axil_dma_regs.sv
stream_fifo.sv
axil_write_master.sv
axil_dma.sv
axil_dma_tb.sv

/* Makefile */
TOP := axil_dma_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

obj_dir/V$(TOP): all.f *.sv *.svh
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module axil_dma

clean:
	rm -rf obj_dir sim.log
